// ==== Makefile ====
# Verilator flow for the controller block testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := sf_user_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_TEXT := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation output holds the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/sf_axil_host.sv ====
// AXI4-Lite slave for the controller block.
// Maps 0x00..0x0C onto the gain RAM (low 18 bits, sign-extended on read)
// and 0x10 onto the read-only saturation counter. Other addresses give SLVERR.
// A read started in the same cycle as a write would collide on RAM port A,
// so a new read takes priority and the write waits one clock.
`timescale 1ns/1ps
`default_nettype none

module sf_axil_host (
	input  logic                clk,
	input  logic                rst_i,
	// Write address and data
	input  sf_pkg::axi_addr_t   awaddr_i,
	input  logic                awvalid_i,
	output logic                awready_o,
	input  sf_pkg::axi_data_t   wdata_i,
	input  logic                wvalid_i,
	output logic                wready_o,
	// Write response
	output logic [1:0]          bresp_o,
	output logic                bvalid_o,
	input  logic                bready_i,
	// Read address and data
	input  sf_pkg::axi_addr_t   araddr_i,
	input  logic                arvalid_i,
	output logic                arready_o,
	output sf_pkg::axi_data_t   rdata_o,
	output logic [1:0]          rresp_o,
	output logic                rvalid_o,
	input  logic                rready_i,
	// Parameter RAM port A
	output sf_pkg::const_addr_t host_addr_o,
	output sf_pkg::sample_t     host_wdata_o,
	output logic                host_we_o,
	input  sf_pkg::sample_t     host_rdata_i,
	// Controller status
	input  sf_pkg::sat_count_t  sat_count_i
);

	localparam int SEXT_W = sf_pkg::AXI_DATA_W - sf_pkg::SAMPLE_W;
	localparam int ZEXT_W = sf_pkg::AXI_DATA_W - sf_pkg::SAT_COUNT_W;

	sf_pkg::axi_addr_t aw_word;
	sf_pkg::axi_addr_t ar_word;
	logic              wr_hit;
	logic              wr_go;
	logic              aw_take;
	logic              ar_take;
	logic              rd_pend;
	logic              rd_stage;
	logic              rd_const;
	logic              rd_count;

	// Byte addresses reduced to word boundaries
	assign aw_word = {awaddr_i[sf_pkg::AXI_ADDR_W-1:2], 2'b00};
	assign ar_word = {araddr_i[sf_pkg::AXI_ADDR_W-1:2], 2'b00};
	assign wr_hit  = (aw_word <= sf_pkg::ADDR_CONST_LAST);

	assign ar_take = arvalid_i && !rd_pend && !arready_o;
	assign aw_take = awvalid_i && wvalid_i && !bvalid_o && !wr_go && !ar_take;

	assign awready_o = wr_go;
	assign wready_o  = wr_go;

	// RAM port A is shared; reads and writes never hand off in the same cycle
	assign host_addr_o  = arready_o ? araddr_i[sf_pkg::CONST_AW+1:2]
	                                : awaddr_i[sf_pkg::CONST_AW+1:2];
	assign host_wdata_o = wdata_i[sf_pkg::SAMPLE_W-1:0];
	assign host_we_o    = wr_go && wr_hit;

	// --------------------------------------------------
	// Write channel
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_go    <= 1'b0;
			bvalid_o <= 1'b0;
		end else begin
			wr_go <= aw_take;
			if (wr_go) begin
				bvalid_o <= 1'b1;
			end else if (bready_i) begin
				bvalid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			bresp_o <= wr_hit ? sf_pkg::RESP_OKAY : sf_pkg::RESP_SLVERR;
		end
	end

	// --------------------------------------------------
	// Read channel
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			arready_o <= 1'b0;
			rd_pend   <= 1'b0;
			rd_stage  <= 1'b0;
			rvalid_o  <= 1'b0;
		end else begin
			arready_o <= ar_take;
			// Address is accepted while arready is high
			rd_stage  <= arready_o;
			if (arready_o) begin
				rd_pend <= 1'b1;
			end else if (rvalid_o && rready_i) begin
				rd_pend <= 1'b0;
			end
			if (rd_stage) begin
				rvalid_o <= 1'b1;
			end else if (rready_i) begin
				rvalid_o <= 1'b0;
			end
		end
	end

	// RAM word is available the cycle after the address
	always_ff @(posedge clk) begin
		if (arready_o) begin
			rd_const <= (ar_word <= sf_pkg::ADDR_CONST_LAST);
			rd_count <= (ar_word == sf_pkg::ADDR_SAT_COUNT);
		end
		if (rd_stage) begin
			if (rd_const) begin
				rdata_o <= {{SEXT_W{host_rdata_i[sf_pkg::SAMPLE_W-1]}}, host_rdata_i};
				rresp_o <= sf_pkg::RESP_OKAY;
			end else if (rd_count) begin
				rdata_o <= {{ZEXT_W{1'b0}}, sat_count_i};
				rresp_o <= sf_pkg::RESP_OKAY;
			end else begin
				rdata_o <= '0;
				rresp_o <= sf_pkg::RESP_SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/sf_dpram.sv ====
// Parameter RAM for the controller gains.
// Port A belongs to the host (read/write), port B to the sequencer (read only).
// Both ports return data one clock after the address.
`timescale 1ns/1ps
`default_nettype none

module sf_dpram (
	input  logic                clk,
	input  sf_pkg::const_addr_t a_addr_i,
	input  sf_pkg::sample_t     a_wdata_i,
	input  logic                a_we_i,
	output sf_pkg::sample_t     a_rdata_o,
	input  sf_pkg::const_addr_t b_addr_i,
	output sf_pkg::sample_t     b_rdata_o
);

	sf_pkg::sample_t mem [0:2**sf_pkg::CONST_AW-1];

	// Host port reads the old word before the write lands
	always_ff @(posedge clk) begin
		if (a_we_i) begin
			mem[a_addr_i] <= a_wdata_i;
		end
		a_rdata_o <= mem[a_addr_i];
	end

	// Controller port runs every cycle
	always_ff @(posedge clk) begin
		b_rdata_o <= mem[b_addr_i];
	end

endmodule

`default_nettype wire

// ==== logic/sf_pkg.sv ====
// Shared widths, vector types, register map and sequencer states for the
// state-feedback controller block. Modules refer to these by scoped names.
`default_nettype none

package sf_pkg;

	// Datapath widths
	localparam int SAMPLE_W    = 18;
	localparam int EXTRA_W     = 4;
	localparam int PROD_W      = 2 * SAMPLE_W;
	localparam int CONST_AW    = 2;
	localparam int SAT_COUNT_W = 7;

	// Host bus widths
	localparam int AXI_ADDR_W = 5;
	localparam int AXI_DATA_W = 32;

	typedef logic signed [SAMPLE_W-1:0]         sample_t;
	typedef logic signed [PROD_W-1:0]           product_t;
	typedef logic signed [SAMPLE_W+EXTRA_W-1:0] trace_t;
	typedef logic [SAT_COUNT_W-1:0]             sat_count_t;
	typedef logic [CONST_AW-1:0]                const_addr_t;
	typedef logic [AXI_ADDR_W-1:0]              axi_addr_t;
	typedef logic [AXI_DATA_W-1:0]              axi_data_t;

	// Register map with gains K0..K3 at 0x00..0x0C
	localparam axi_addr_t ADDR_CONST_LAST = 5'h0C;
	localparam axi_addr_t ADDR_SAT_COUNT  = 5'h10;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic [1:0] {IDLE, FETCH, DRAIN} seq_state_t;

endpackage

`default_nettype wire

// ==== logic/sf_user.sv ====
// State-feedback controller core.
// On a trigger it latches one measurement, fetches gains K0..K3 from the
// parameter RAM and produces a..d = sat((meas * Kn) >>> gain_shift).
// The outputs are summed into trace_o, which is marked by trace_strobe_o.
// ce_i low freezes the sequencer and the whole datapath for that clock.
`timescale 1ns/1ps
`default_nettype none

module sf_user #(
	parameter int gain_shift = 12
) (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                ce_i,
	input  sf_pkg::sample_t     meas_i,
	input  logic                trigger_i,
	output sf_pkg::const_addr_t rd_addr_o,
	input  sf_pkg::sample_t     rd_data_i,
	output sf_pkg::sample_t     a_o,
	output sf_pkg::sample_t     b_o,
	output sf_pkg::sample_t     c_o,
	output sf_pkg::sample_t     d_o,
	output sf_pkg::trace_t      trace_o,
	output logic                trace_strobe_o,
	output sf_pkg::sat_count_t  sat_count_o
);

	localparam int HEAD_W = sf_pkg::PROD_W - sf_pkg::SAMPLE_W + 1;
	localparam sf_pkg::sample_t SAMPLE_MAX = {1'b0, {(sf_pkg::SAMPLE_W-1){1'b1}}};
	localparam sf_pkg::sample_t SAMPLE_MIN = {1'b1, {(sf_pkg::SAMPLE_W-1){1'b0}}};
	localparam sf_pkg::const_addr_t LAST_TAG = '1;

	sf_pkg::seq_state_t  state;
	sf_pkg::const_addr_t fetch_cnt;
	sf_pkg::sample_t     meas_r;
	logic                start;
	logic                run_done;

	// Pipeline valids and output-index tags
	logic                data_v;
	sf_pkg::const_addr_t data_tag;
	logic                prod_v;
	sf_pkg::const_addr_t prod_tag;
	logic                out_v;
	sf_pkg::const_addr_t out_tag;

	sf_pkg::product_t    prod_r;
	sf_pkg::product_t    shifted;
	logic                clamp;
	sf_pkg::sample_t     clamped;
	sf_pkg::trace_t      acc;

	// During a stall the RAM re-reads the word still waiting for the multiplier
	assign rd_addr_o = ce_i ? fetch_cnt : data_tag;
	assign start     = (state == sf_pkg::IDLE) && trigger_i;
	// Last output register written on the previous ce cycle
	assign run_done  = (state == sf_pkg::DRAIN) && out_v && (out_tag == LAST_TAG);

	// --------------------------------------------------
	// Sequencer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state          <= sf_pkg::IDLE;
			fetch_cnt      <= '0;
			trace_strobe_o <= 1'b0;
		end else begin
			trace_strobe_o <= 1'b0;
			if (ce_i) begin
				case (state)
					sf_pkg::IDLE: begin
						if (trigger_i) begin
							state     <= sf_pkg::FETCH;
							fetch_cnt <= '0;
						end
					end
					sf_pkg::FETCH: begin
						fetch_cnt <= fetch_cnt + 1'b1;
						if (fetch_cnt == LAST_TAG) begin
							state <= sf_pkg::DRAIN;
						end
					end
					sf_pkg::DRAIN: begin
						if (run_done) begin
							state          <= sf_pkg::IDLE;
							trace_strobe_o <= 1'b1;
						end
					end
					default: state <= sf_pkg::IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			data_v <= 1'b0;
			prod_v <= 1'b0;
			out_v  <= 1'b0;
		end else if (ce_i) begin
			data_v <= (state == sf_pkg::FETCH);
			prod_v <= data_v;
			out_v  <= prod_v;
		end
	end

	// --------------------------------------------------
	// Multiply stage
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (ce_i) begin
			if (start) begin
				meas_r <= meas_i;
			end
			data_tag <= fetch_cnt;
			prod_tag <= data_tag;
			out_tag  <= prod_tag;
			prod_r   <= meas_r * rd_data_i;
		end
	end

	// Scale and clamp to the sample range
	always_comb begin
		shifted = prod_r >>> gain_shift;
		clamp   = (shifted[sf_pkg::PROD_W-1:sf_pkg::SAMPLE_W-1]
		           != {HEAD_W{shifted[sf_pkg::PROD_W-1]}});
		if (!clamp) begin
			clamped = shifted[sf_pkg::SAMPLE_W-1:0];
		end else if (shifted[sf_pkg::PROD_W-1]) begin
			clamped = SAMPLE_MIN;
		end else begin
			clamped = SAMPLE_MAX;
		end
	end

	// --------------------------------------------------
	// Output registers, trace and clamp counter
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			a_o         <= '0;
			b_o         <= '0;
			c_o         <= '0;
			d_o         <= '0;
			acc         <= '0;
			trace_o     <= '0;
			sat_count_o <= '0;
		end else if (ce_i) begin
			if (start) begin
				acc <= '0;
			end
			if (prod_v) begin
				case (prod_tag)
					2'd0:    a_o <= clamped;
					2'd1:    b_o <= clamped;
					2'd2:    c_o <= clamped;
					default: d_o <= clamped;
				endcase
				acc <= acc + clamped;
				if (clamp) begin
					sat_count_o <= sat_count_o + 1'b1;
				end
			end
			if (run_done) begin
				trace_o <= acc;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/sf_user_top.sv ====
// Top level of the controller block.
// The host programs gains K0..K3 over AXI4-Lite into the parameter RAM;
// the controller core reads them on each trigger.
// gain_shift sets the right shift applied to each product.
`timescale 1ns/1ps
`default_nettype none

module sf_user_top #(
	parameter int gain_shift = 12
) (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               ce_i,
	input  sf_pkg::sample_t    meas_i,
	input  logic               trigger_i,
	// AXI4-Lite slave
	input  sf_pkg::axi_addr_t  awaddr_i,
	input  logic               awvalid_i,
	output logic               awready_o,
	input  sf_pkg::axi_data_t  wdata_i,
	input  logic               wvalid_i,
	output logic               wready_o,
	output logic [1:0]         bresp_o,
	output logic               bvalid_o,
	input  logic               bready_i,
	input  sf_pkg::axi_addr_t  araddr_i,
	input  logic               arvalid_i,
	output logic               arready_o,
	output sf_pkg::axi_data_t  rdata_o,
	output logic [1:0]         rresp_o,
	output logic               rvalid_o,
	input  logic               rready_i,
	// Controller results
	output sf_pkg::sample_t    a_o,
	output sf_pkg::sample_t    b_o,
	output sf_pkg::sample_t    c_o,
	output sf_pkg::sample_t    d_o,
	output sf_pkg::trace_t     trace_o,
	output logic               trace_strobe_o,
	output sf_pkg::sat_count_t sat_count_o
);

	sf_pkg::const_addr_t host_addr;
	sf_pkg::sample_t     host_wdata;
	logic                host_we;
	sf_pkg::sample_t     host_rdata;
	sf_pkg::const_addr_t rd_addr;
	sf_pkg::sample_t     rd_data;

	sf_axil_host u_host (
		.clk(clk), .rst_i(rst_i),
		.awaddr_i(awaddr_i), .awvalid_i(awvalid_i), .awready_o(awready_o),
		.wdata_i(wdata_i), .wvalid_i(wvalid_i), .wready_o(wready_o),
		.bresp_o(bresp_o), .bvalid_o(bvalid_o), .bready_i(bready_i),
		.araddr_i(araddr_i), .arvalid_i(arvalid_i), .arready_o(arready_o),
		.rdata_o(rdata_o), .rresp_o(rresp_o), .rvalid_o(rvalid_o),
		.rready_i(rready_i),
		.host_addr_o(host_addr), .host_wdata_o(host_wdata), .host_we_o(host_we),
		.host_rdata_i(host_rdata), .sat_count_i(sat_count_o)
	);

	// Gain store with the host on port A and the sequencer on port B
	sf_dpram u_const_mem (
		.clk(clk),
		.a_addr_i(host_addr), .a_wdata_i(host_wdata), .a_we_i(host_we),
		.a_rdata_o(host_rdata),
		.b_addr_i(rd_addr), .b_rdata_o(rd_data)
	);

	sf_user #(.gain_shift(gain_shift)) u_user (
		.clk(clk), .rst_i(rst_i), .ce_i(ce_i),
		.meas_i(meas_i), .trigger_i(trigger_i),
		.rd_addr_o(rd_addr), .rd_data_i(rd_data),
		.a_o(a_o), .b_o(b_o), .c_o(c_o), .d_o(d_o),
		.trace_o(trace_o), .trace_strobe_o(trace_strobe_o),
		.sat_count_o(sat_count_o)
	);

endmodule

`default_nettype wire

// ==== src.f ====
logic/sf_pkg.sv
logic/sf_dpram.sv
logic/sf_axil_host.sv
logic/sf_user.sv
logic/sf_user_top.sv
verif/sf_clkgen.sv
verif/sf_user_tb.sv

// ==== verif/sf_clkgen.sv ====
// Clock and reset source for the controller testbench.
// Runs a free clock and holds the synchronous reset high for the first cycles.
`timescale 1ns/1ps
`default_nettype none

module sf_clkgen #(
	parameter int period_ns  = 10,
	parameter int rst_cycles = 8
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(period_ns / 2) clk_o = ~clk_o;
	end

	// Reset drops just after a rising edge
	initial begin
		rst_o = 1'b1;
		repeat (rst_cycles) @(posedge clk_o);
		#1;
		rst_o = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/sf_user_tb.sv ====
// Testbench for the controller block top level.
// Programs gains over AXI4-Lite, fires triggers with and without clock-enable
// stalls and checks every strobe against a model of the multiply, shift and
// clamp rule. Also covers back-pressure, ignored triggers and bad addresses.
`timescale 1ns/1ps
`default_nettype none

module sf_user_tb;

	localparam int GAIN_SHIFT  = 12;
	localparam int RUNS_BASIC  = 30;
	localparam int RUNS_SAT    = 36;
	localparam int RUNS_CE     = 20;
	localparam int RUNS_RETRIG = 6;
	localparam int RUNS_TOTAL  = RUNS_BASIC + RUNS_SAT + RUNS_CE + RUNS_RETRIG;
	localparam int AXI_OPS     = 260;
	// 40 clocks per run, 16 per AXI transfer, plus idle gaps
	localparam int WATCHDOG_CYCLES = RUNS_TOTAL * 40 + AXI_OPS * 16 + 1000;
	localparam longint SAMPLE_MAX = 131071;
	localparam longint SAMPLE_MIN = -131072;
	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	typedef sf_pkg::sample_t [3:0] sample_quad_t;

	logic                clk;
	logic                rst_i;
	logic                ce_i;
	sf_pkg::sample_t     meas_i;
	logic                trigger_i;
	sf_pkg::axi_addr_t   awaddr_i;
	logic                awvalid_i;
	logic                awready_o;
	sf_pkg::axi_data_t   wdata_i;
	logic                wvalid_i;
	logic                wready_o;
	logic [1:0]          bresp_o;
	logic                bvalid_o;
	logic                bready_i;
	sf_pkg::axi_addr_t   araddr_i;
	logic                arvalid_i;
	logic                arready_o;
	sf_pkg::axi_data_t   rdata_o;
	logic [1:0]          rresp_o;
	logic                rvalid_o;
	logic                rready_i;
	sf_pkg::sample_t     a_o;
	sf_pkg::sample_t     b_o;
	sf_pkg::sample_t     c_o;
	sf_pkg::sample_t     d_o;
	sf_pkg::trace_t      trace_o;
	logic                trace_strobe_o;
	sf_pkg::sat_count_t  sat_count_o;

	logic [31:0]         stim_state = 32'd73642;
	logic                ce_random_en = 1'b0;
	sample_quad_t        gains;
	int                  sat_total = 0;
	int                  run_count = 0;
	int                  strobe_count = 0;
	logic                strobe_prev = 1'b0;
	sample_quad_t        exp_y_q[$];
	sf_pkg::trace_t      exp_tr_q[$];
	sf_pkg::sat_count_t  exp_cnt_q[$];

	sf_clkgen #(.period_ns(10), .rst_cycles(8)) u_clkgen (.clk_o(clk), .rst_o(rst_i));

	sf_user_top #(.gain_shift(GAIN_SHIFT)) u_dut (.*);

	// --------------------------------------------------
	// Random numbers and reference model
	// --------------------------------------------------
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper halves only because the low LCG bits repeat too quickly
	function automatic sf_pkg::axi_data_t rand_word();
		logic [31:0] hi;
		stim_state = lcg_step(stim_state);
		hi = stim_state;
		stim_state = lcg_step(stim_state);
		return {hi[31:16], stim_state[31:16]};
	endfunction

	function automatic int rand_range(input int n);
		sf_pkg::axi_data_t w;
		w = rand_word();
		return int'({1'b0, w[30:0]}) % n;
	endfunction

	function automatic sample_quad_t rand_gains(input logic full);
		sample_quad_t g;
		sf_pkg::axi_data_t w;
		for (int i = 0; i < 4; i++) begin
			w = rand_word();
			if (full) begin
				g[i] = w[17:0];
			end else begin
				g[i] = $signed(w[13:0]);
			end
		end
		return g;
	endfunction

	function automatic sf_pkg::axi_data_t sext_gain(input sf_pkg::sample_t g);
		int v;
		v = g;
		return sf_pkg::axi_data_t'(v);
	endfunction

	// y = clamp((meas * k) >>> shift) and the trace is the sum of the four
	function automatic void ref_run(input sf_pkg::sample_t meas, input sample_quad_t k,
			input int shift, output sample_quad_t y, output sf_pkg::trace_t tr,
			output int nclamp);
		sf_pkg::sample_t ki;
		longint p;
		int sum;
		sum = 0;
		nclamp = 0;
		for (int i = 0; i < 4; i++) begin
			ki = k[i];
			p = (longint'(meas) * longint'(ki)) >>> shift;
			if (p > SAMPLE_MAX) begin
				p = SAMPLE_MAX;
				nclamp++;
			end else if (p < SAMPLE_MIN) begin
				p = SAMPLE_MIN;
				nclamp++;
			end
			y[i] = sf_pkg::sample_t'(p);
			sum += int'(p);
		end
		tr = sf_pkg::trace_t'(sum);
	endfunction

	// --------------------------------------------------
	// Error reporting and compares
	// --------------------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_sample(input string name, input sf_pkg::sample_t exp,
			input sf_pkg::sample_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_trace(input string name, input sf_pkg::trace_t exp,
			input sf_pkg::trace_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input sf_pkg::sat_count_t exp,
			input sf_pkg::sat_count_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_data(input string name, input sf_pkg::axi_data_t exp,
			input sf_pkg::axi_data_t act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
		end
	endtask

	// --------------------------------------------------
	// Bus and run tasks return 1 ns after a rising edge
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic axi_write(input sf_pkg::axi_addr_t addr, input sf_pkg::axi_data_t data,
			input int hold, output logic [1:0] resp);
		awaddr_i  = addr;
		wdata_i   = data;
		awvalid_i = 1'b1;
		wvalid_i  = 1'b1;
		@(negedge clk);
		while (!(awready_o && wready_o)) @(negedge clk);
		next_cycle();
		awvalid_i = 1'b0;
		wvalid_i  = 1'b0;
		@(negedge clk);
		while (!bvalid_o) @(negedge clk);
		resp = bresp_o;
		repeat (hold) begin
			@(negedge clk);
			if (!bvalid_o || bresp_o !== resp) begin
				abort_run("Write response changed while bready was low");
			end
		end
		next_cycle();
		bready_i = 1'b1;
		next_cycle();
		bready_i = 1'b0;
	endtask

	task automatic axi_read(input sf_pkg::axi_addr_t addr, input int hold,
			output sf_pkg::axi_data_t data, output logic [1:0] resp);
		araddr_i  = addr;
		arvalid_i = 1'b1;
		@(negedge clk);
		while (!arready_o) @(negedge clk);
		next_cycle();
		arvalid_i = 1'b0;
		@(negedge clk);
		while (!rvalid_o) @(negedge clk);
		data = rdata_o;
		resp = rresp_o;
		repeat (hold) begin
			@(negedge clk);
			if (!rvalid_o || rdata_o !== data || rresp_o !== resp) begin
				abort_run("Read data or response changed while rready was low");
			end
		end
		next_cycle();
		rready_i = 1'b1;
		next_cycle();
		rready_i = 1'b0;
	endtask

	task automatic read_and_check(input sf_pkg::axi_addr_t addr, input sf_pkg::axi_data_t exp,
			input logic [1:0] exp_resp, input int hold);
		sf_pkg::axi_data_t data;
		logic [1:0] resp;
		axi_read(addr, hold, data, resp);
		check_resp($sformatf("rresp_o[0x%h]", addr), exp_resp, resp);
		check_data($sformatf("rdata_o[0x%h]", addr), exp, data);
	endtask

	// Upper data bits are junk and only the low 18 land in the RAM
	task automatic write_gains(input sample_quad_t g, input int hold_max);
		sf_pkg::axi_data_t w;
		logic [1:0] resp;
		for (int i = 0; i < 4; i++) begin
			w = rand_word();
			axi_write(sf_pkg::axi_addr_t'(4 * i), {w[31:18], g[i]}, rand_range(hold_max + 1),
				resp);
			check_resp("bresp_o", OKAY, resp);
		end
		gains = g;
	endtask

	task automatic start_run(input sf_pkg::sample_t meas);
		sample_quad_t y;
		sf_pkg::trace_t tr;
		int n;
		ref_run(meas, gains, GAIN_SHIFT, y, tr, n);
		sat_total += n;
		exp_y_q.push_back(y);
		exp_tr_q.push_back(tr);
		exp_cnt_q.push_back(sf_pkg::sat_count_t'(sat_total % 128));
		run_count++;
		meas_i    = meas;
		trigger_i = 1'b1;
		// Trigger only counts on an edge with ce high
		@(negedge clk);
		while (!ce_i) @(negedge clk);
		next_cycle();
		trigger_i = 1'b0;
	endtask

	task automatic wait_runs_done();
		while (strobe_count != run_count) next_cycle();
	endtask

	// --------------------------------------------------
	// Clock enable, result compare and watchdog
	// --------------------------------------------------
	initial begin : ce_driver
		logic [31:0] ce_state;
		ce_state = lcg_step(32'd73642);
		ce_i = 1'b1;
		forever begin
			next_cycle();
			if (ce_random_en) begin
				ce_state = lcg_step(ce_state);
				ce_i = (ce_state[31:30] != 2'b00);
			end else begin
				ce_i = 1'b1;
			end
		end
	end

	always @(negedge clk) begin : compare_results
		sample_quad_t y;
		if (!rst_i && trace_strobe_o) begin
			if (strobe_prev) begin
				abort_run("trace_strobe_o stayed high for more than one clock");
			end else if (exp_tr_q.size() == 0) begin
				abort_run("trace_strobe_o pulsed without an accepted trigger");
			end else begin
				y = exp_y_q.pop_front();
				check_sample("a_o", y[0], a_o);
				check_sample("b_o", y[1], b_o);
				check_sample("c_o", y[2], c_o);
				check_sample("d_o", y[3], d_o);
				check_trace("trace_o", exp_tr_q.pop_front(), trace_o);
				check_count("sat_count_o", exp_cnt_q.pop_front(), sat_count_o);
				strobe_count++;
			end
		end
		strobe_prev = trace_strobe_o;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Timeout, the test sequence did not finish in time");
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin : main_sequence
		sample_quad_t g;
		sf_pkg::axi_data_t w;
		int m;
		logic [1:0] resp;
		meas_i    = '0;
		trigger_i = 1'b0;
		awaddr_i  = '0;
		awvalid_i = 1'b0;
		wdata_i   = '0;
		wvalid_i  = 1'b0;
		bready_i  = 1'b0;
		araddr_i  = '0;
		arvalid_i = 1'b0;
		rready_i  = 1'b0;
		gains     = '0;
		@(negedge clk);
		while (rst_i) @(negedge clk);
		next_cycle();

		// Results come out of reset cleared
		check_sample("a_o", '0, a_o);
		check_sample("b_o", '0, b_o);
		check_sample("c_o", '0, c_o);
		check_sample("d_o", '0, d_o);
		check_trace("trace_o", '0, trace_o);
		check_count("sat_count_o", '0, sat_count_o);

		// Constant write and read-back
		g = rand_gains(1'b1);
		write_gains(g, 0);
		for (int i = 0; i < 4; i++) begin
			read_and_check(sf_pkg::axi_addr_t'(4 * i), sext_gain(g[i]), OKAY, 0);
		end

		// Plain runs
		for (int r = 0; r < RUNS_BASIC; r++) begin
			write_gains(rand_gains(1'b0), 0);
			w = rand_word();
			start_run(w[17:0]);
			wait_runs_done();
		end

		// Saturation with enough clamps to wrap the 7-bit count
		g[0] = 131071;
		g[1] = -131072;
		g[2] = 100000;
		g[3] = -90000;
		write_gains(g, 0);
		for (int r = 0; r < RUNS_SAT; r++) begin
			m = 8192 + rand_range(120000);
			w = rand_word();
			start_run(sf_pkg::sample_t'(w[0] ? -m : m));
			wait_runs_done();
			if (r % 6 == 5) begin
				read_and_check(5'h10, sf_pkg::axi_data_t'(sat_total % 128), OKAY, 0);
			end
		end

		// Clock-enable stalls
		ce_random_en = 1'b1;
		for (int r = 0; r < RUNS_CE; r++) begin
			write_gains(rand_gains(r % 2 == 1), 0);
			w = rand_word();
			start_run(w[17:0]);
			wait_runs_done();
		end
		ce_random_en = 1'b0;
		next_cycle();
		next_cycle();

		// Back-pressure and triggers while busy
		g = rand_gains(1'b1);
		write_gains(g, 6);
		for (int i = 0; i < 4; i++) begin
			read_and_check(sf_pkg::axi_addr_t'(4 * i), sext_gain(g[i]), OKAY, 1 + rand_range(6));
		end
		for (int r = 0; r < RUNS_RETRIG; r++) begin
			w = rand_word();
			start_run(w[17:0]);
			next_cycle();
			next_cycle();
			// A wrongly accepted trigger would latch this other measurement
			meas_i    = ~meas_i;
			trigger_i = 1'b1;
			next_cycle();
			next_cycle();
			trigger_i = 1'b0;
			read_and_check(sf_pkg::axi_addr_t'(4 * (r % 4)), sext_gain(g[r % 4]), OKAY,
				1 + rand_range(6));
			wait_runs_done();
			repeat (10) next_cycle();
		end
		read_and_check(5'h10, sf_pkg::axi_data_t'(sat_total % 128), OKAY, 3);

		// Bad addresses leave the gains alone
		w = rand_word();
		axi_write(5'h14, w, 2, resp);
		check_resp("bresp_o", SLVERR, resp);
		read_and_check(5'h18, '0, SLVERR, 2);
		for (int i = 0; i < 4; i++) begin
			read_and_check(sf_pkg::axi_addr_t'(4 * i), sext_gain(gains[i]), OKAY, 0);
		end

		repeat (10) next_cycle();
		if (exp_tr_q.size() != 0 || strobe_count != run_count) begin
			abort_run("An accepted trigger finished without a strobe");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

`default_nettype wire
